// File: verilog/soc_l2_pkg.sv
// Shared definitions for the L2 interconnect
// Memory map, alias remapping, widths, bank decode and response types
// Referenced by scoped names from the RTL and the testbench
package soc_l2_pkg;

    //////////////////////////////////////////////////////////////
    // Widths and counts
    //////////////////////////////////////////////////////////////

    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int BE_W       = 4;
    localparam int BYTE_W     = DATA_W / BE_W;
    localparam int NR_MASTERS = 2;
    localparam int NR_BANKS   = 4;
    localparam int BANK_WORDS = 256;

    // Bank decode, word interleaved across the banks
    localparam int BANK_IDX_W  = 2;
    localparam int BANK_WORD_W = 8;
    localparam int BANK_LSB    = 2;
    localparam int WORD_LSB    = BANK_LSB + BANK_IDX_W;

    // Address bits 31..20 carry the region prefix
    localparam int PREFIX_W = 12;

    //////////////////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////////////////

    typedef logic [ADDR_W-1:0]      addr_t;
    typedef logic [DATA_W-1:0]      data_t;
    typedef logic [BE_W-1:0]        be_t;
    typedef logic [BANK_IDX_W-1:0]  bank_idx_t;
    typedef logic [BANK_WORD_W-1:0] bank_word_t;

    // Master ports, also the index into every per-master vector
    typedef enum logic [0:0] {
        MASTER_FC_DATA = 1'b0,
        MASTER_UDMA    = 1'b1
    } master_id_t;

    // Response opcode, ERR for any access outside the L2 region
    typedef enum logic [0:0] {
        OPC_OK  = 1'b0,
        OPC_ERR = 1'b1
    } resp_opc_t;

    //////////////////////////////////////////////////////////////
    // Memory map
    //////////////////////////////////////////////////////////////

    // Interleaved region, end is inclusive (4 KiB)
    localparam addr_t L2_START_ADDR = 32'h1c00_0000;
    localparam addr_t L2_END_ADDR   = 32'h1c00_0fff;

    // Legacy alias on the fc_data port, prefix 000 maps to 1c0
    localparam logic [PREFIX_W-1:0] ALIAS_PREFIX = 12'h000;
    localparam logic [PREFIX_W-1:0] L2_PREFIX    = 12'h1c0;

endpackage

// File: verilog/tcdm_bank_if.sv
// Request and response wiring of one L2 bank
// Request fields are indexed by master, the response is one per bank
`timescale 1ns/100ps

interface tcdm_bank_if;

    // Request side, one lane per master
    logic [soc_l2_pkg::NR_MASTERS-1:0] req;
    logic [soc_l2_pkg::NR_MASTERS-1:0] gnt;
    logic [soc_l2_pkg::NR_MASTERS-1:0] wen;
    soc_l2_pkg::bank_word_t            word  [soc_l2_pkg::NR_MASTERS];
    soc_l2_pkg::data_t                 wdata [soc_l2_pkg::NR_MASTERS];
    soc_l2_pkg::be_t                   be    [soc_l2_pkg::NR_MASTERS];

    // Registered response, tagged with the issuing master
    logic                              r_valid;
    soc_l2_pkg::master_id_t            r_master;
    soc_l2_pkg::data_t                 r_rdata;

    // Address decode side
    modport router (
        output req, wen, word, wdata, be,
        input  gnt
    );

    // Bank side
    modport bank (
        input  req, wen, word, wdata, be,
        output gnt, r_valid, r_master, r_rdata
    );

    // Response collection side
    modport resp (
        input  r_valid, r_master, r_rdata
    );

endinterface

// File: verilog/l2_req_router.sv
// Request router for the L2 masters
// Remaps the fc_data alias, checks the L2 region and steers each request
// to its interleaved bank. Out-of-range requests are granted at once
// and flagged for an error response in the next cycle
`timescale 1ns/100ps

module l2_req_router (
    input  logic                              clk_i,
    input  logic                              arst_n_i,
    input  logic [soc_l2_pkg::NR_MASTERS-1:0] req_i,
    input  soc_l2_pkg::addr_t                 add_i   [soc_l2_pkg::NR_MASTERS],
    input  logic [soc_l2_pkg::NR_MASTERS-1:0] wen_i,
    input  soc_l2_pkg::data_t                 wdata_i [soc_l2_pkg::NR_MASTERS],
    input  soc_l2_pkg::be_t                   be_i    [soc_l2_pkg::NR_MASTERS],
    output logic [soc_l2_pkg::NR_MASTERS-1:0] gnt_o,
    output logic [soc_l2_pkg::NR_MASTERS-1:0] err_valid_o,
    tcdm_bank_if.router                       bank_if [soc_l2_pkg::NR_BANKS]
);

    logic [soc_l2_pkg::NR_MASTERS-1:0] in_range;
    logic [soc_l2_pkg::NR_MASTERS-1:0] err_valid_q;

    //////////////////////////////////////////////////////////////
    // Per-master decode
    //////////////////////////////////////////////////////////////

    for (genvar m = 0; m < soc_l2_pkg::NR_MASTERS; m++) begin : gen_master
        soc_l2_pkg::addr_t               addr;
        soc_l2_pkg::bank_idx_t           bank;
        logic [soc_l2_pkg::NR_BANKS-1:0] sent;
        logic [soc_l2_pkg::NR_BANKS-1:0] bank_gnt;

        // Legacy alias, only the fc_data port sees it
        always_comb begin
            addr = add_i[m];
            if ((m == int'(soc_l2_pkg::MASTER_FC_DATA)) &&
                (add_i[m][soc_l2_pkg::ADDR_W-1 -: soc_l2_pkg::PREFIX_W] ==
                 soc_l2_pkg::ALIAS_PREFIX)) begin
                addr[soc_l2_pkg::ADDR_W-1 -: soc_l2_pkg::PREFIX_W] = soc_l2_pkg::L2_PREFIX;
            end
        end

        // Region check on the remapped address
        assign in_range[m] = (addr >= soc_l2_pkg::L2_START_ADDR) &&
                             (addr <= soc_l2_pkg::L2_END_ADDR);
        assign bank = addr[soc_l2_pkg::BANK_LSB +: soc_l2_pkg::BANK_IDX_W];

        // Fan out to every bank, req only toward the decoded one
        for (genvar b = 0; b < soc_l2_pkg::NR_BANKS; b++) begin : gen_bank
            assign sent[b] = req_i[m] && in_range[m] &&
                             (bank == soc_l2_pkg::bank_idx_t'(b));
            assign bank_if[b].req[m]   = sent[b];
            assign bank_if[b].wen[m]   = wen_i[m];
            assign bank_if[b].word[m]  = addr[soc_l2_pkg::WORD_LSB +: soc_l2_pkg::BANK_WORD_W];
            assign bank_if[b].wdata[m] = wdata_i[m];
            assign bank_if[b].be[m]    = be_i[m];
            assign bank_gnt[b]         = bank_if[b].gnt[m];
        end

        // Bank grant in range, immediate grant otherwise
        assign gnt_o[m] = in_range[m] ? bank_gnt[bank] : req_i[m];

        // A request is taken by the decoded bank only, never by another one
        assert property (@(posedge clk_i) disable iff (!arst_n_i) (bank_gnt & ~sent) == '0)
            else $error("router: master %0d granted by a bank it was not sent to", m);
    end

    //////////////////////////////////////////////////////////////
    // Error flag, answered one cycle after the transfer
    //////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            err_valid_q <= '0;
        end else begin
            err_valid_q <= req_i & ~in_range;
        end
    end

    assign err_valid_o = err_valid_q;

endmodule

// File: verilog/l2_bank.sv
// One word-interleaved L2 bank
// Round-robin arbitration between the masters, a byte-enabled word
// memory and a response registered one cycle after the grant
`timescale 1ns/100ps

module l2_bank (
    input  logic      clk_i,
    input  logic      arst_n_i,
    tcdm_bank_if.bank bus
);

    soc_l2_pkg::data_t                 mem [soc_l2_pkg::BANK_WORDS];
    logic [soc_l2_pkg::NR_MASTERS-1:0] gnt;
    logic                              conflict;
    logic                              granted;
    soc_l2_pkg::master_id_t            sel;
    soc_l2_pkg::master_id_t            rr_q;
    logic                              r_valid_q;
    soc_l2_pkg::master_id_t            r_master_q;
    soc_l2_pkg::data_t                 r_rdata_q;

    //////////////////////////////////////////////////////////////
    // Arbitration
    //////////////////////////////////////////////////////////////

    assign conflict = &bus.req;

    // Pass requests through, rr pointer picks on a conflict
    always_comb begin
        gnt = bus.req;
        if (conflict) begin
            gnt       = '0;
            gnt[rr_q] = 1'b1;
        end
    end

    assign granted = |gnt;
    assign sel     = gnt[soc_l2_pkg::MASTER_UDMA] ? soc_l2_pkg::MASTER_UDMA :
                                                    soc_l2_pkg::MASTER_FC_DATA;
    assign bus.gnt = gnt;

    // Pointer only moves on a conflict, favours the loser next time
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rr_q      <= soc_l2_pkg::MASTER_FC_DATA;
            r_valid_q <= 1'b0;
        end else begin
            r_valid_q <= granted;
            if (conflict) begin
                rr_q <= (rr_q == soc_l2_pkg::MASTER_FC_DATA) ? soc_l2_pkg::MASTER_UDMA :
                                                               soc_l2_pkg::MASTER_FC_DATA;
            end
        end
    end

    //////////////////////////////////////////////////////////////
    // Memory and response payload
    //////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (granted) begin
            r_master_q <= sel;
            if (!bus.wen[sel]) begin
                // Write, merge enabled bytes only
                for (int i = 0; i < soc_l2_pkg::BE_W; i++) begin
                    if (bus.be[sel][i]) begin
                        mem[bus.word[sel]][i*soc_l2_pkg::BYTE_W +: soc_l2_pkg::BYTE_W] <=
                            bus.wdata[sel][i*soc_l2_pkg::BYTE_W +: soc_l2_pkg::BYTE_W];
                    end
                end
                r_rdata_q <= '0;
            end else begin
                r_rdata_q <= mem[bus.word[sel]];
            end
        end
    end

    assign bus.r_valid  = r_valid_q;
    assign bus.r_master = r_master_q;
    assign bus.r_rdata  = r_rdata_q;

    // Round robin, a master that lost a conflict wins its next cycle
    for (genvar m = 0; m < soc_l2_pkg::NR_MASTERS; m++) begin : gen_fair
        assert property (@(posedge clk_i) disable iff (!arst_n_i)
                         ($past(bus.req[m] && !bus.gnt[m]) && bus.req[m]) |-> bus.gnt[m])
            else $error("bank: master %0d waited more than one cycle", m);
    end

endmodule

// File: verilog/l2_resp_mux.sv
// Response collection for the L2 masters
// Routes each bank response back to its master by tag, falls back
// to the router error flag with an ERR opcode and zero data
`timescale 1ns/100ps

module l2_resp_mux (
    input  logic                              clk_i,
    input  logic                              arst_n_i,
    tcdm_bank_if.resp                         bank_if [soc_l2_pkg::NR_BANKS],
    input  logic [soc_l2_pkg::NR_MASTERS-1:0] err_valid_i,
    output logic [soc_l2_pkg::NR_MASTERS-1:0] r_valid_o,
    output soc_l2_pkg::data_t                 r_rdata_o [soc_l2_pkg::NR_MASTERS],
    output soc_l2_pkg::resp_opc_t             r_opc_o   [soc_l2_pkg::NR_MASTERS]
);

    soc_l2_pkg::data_t bank_rdata [soc_l2_pkg::NR_BANKS];

    for (genvar b = 0; b < soc_l2_pkg::NR_BANKS; b++) begin : gen_bank
        assign bank_rdata[b] = bank_if[b].r_rdata;
    end

    for (genvar m = 0; m < soc_l2_pkg::NR_MASTERS; m++) begin : gen_master
        logic [soc_l2_pkg::NR_BANKS-1:0] hit;

        // Bank responses tagged for this master
        for (genvar b = 0; b < soc_l2_pkg::NR_BANKS; b++) begin : gen_hit
            assign hit[b] = bank_if[b].r_valid &&
                            (bank_if[b].r_master == soc_l2_pkg::master_id_t'(m));
        end

        // Zero data unless a bank answers
        always_comb begin
            r_rdata_o[m] = '0;
            for (int i = 0; i < soc_l2_pkg::NR_BANKS; i++) begin
                if (hit[i]) begin
                    r_rdata_o[m] = bank_rdata[i];
                end
            end
        end

        assign r_valid_o[m] = (|hit) || err_valid_i[m];
        assign r_opc_o[m]   = (err_valid_i[m] && !(|hit)) ? soc_l2_pkg::OPC_ERR :
                                                            soc_l2_pkg::OPC_OK;

        // One transfer per cycle per master, so one source per response
        assert property (@(posedge clk_i) disable iff (!arst_n_i)
                         $onehot0({hit, err_valid_i[m]}))
            else $error("resp_mux: master %0d has several response sources", m);
    end

endmodule

// File: verilog/soc_l2_interconnect.sv
// L2 interconnect top level
// Two TCDM masters (fc_data, uDMA) onto four word-interleaved banks
// Fixed latency of one cycle from transfer to response
`timescale 1ns/100ps

module soc_l2_interconnect (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    // Fabric controller data port
    input  logic                  fc_data_req_i,
    input  soc_l2_pkg::addr_t     fc_data_add_i,
    input  logic                  fc_data_wen_i,
    input  soc_l2_pkg::data_t     fc_data_wdata_i,
    input  soc_l2_pkg::be_t       fc_data_be_i,
    output logic                  fc_data_gnt_o,
    output logic                  fc_data_r_valid_o,
    output soc_l2_pkg::data_t     fc_data_r_rdata_o,
    output soc_l2_pkg::resp_opc_t fc_data_r_opc_o,
    // uDMA channel
    input  logic                  udma_req_i,
    input  soc_l2_pkg::addr_t     udma_add_i,
    input  logic                  udma_wen_i,
    input  soc_l2_pkg::data_t     udma_wdata_i,
    input  soc_l2_pkg::be_t       udma_be_i,
    output logic                  udma_gnt_o,
    output logic                  udma_r_valid_o,
    output soc_l2_pkg::data_t     udma_r_rdata_o,
    output soc_l2_pkg::resp_opc_t udma_r_opc_o
);

    logic [soc_l2_pkg::NR_MASTERS-1:0] req;
    logic [soc_l2_pkg::NR_MASTERS-1:0] wen;
    logic [soc_l2_pkg::NR_MASTERS-1:0] gnt;
    logic [soc_l2_pkg::NR_MASTERS-1:0] err_valid;
    logic [soc_l2_pkg::NR_MASTERS-1:0] r_valid;
    soc_l2_pkg::addr_t                 add     [soc_l2_pkg::NR_MASTERS];
    soc_l2_pkg::data_t                 wdata   [soc_l2_pkg::NR_MASTERS];
    soc_l2_pkg::be_t                   be      [soc_l2_pkg::NR_MASTERS];
    soc_l2_pkg::data_t                 r_rdata [soc_l2_pkg::NR_MASTERS];
    soc_l2_pkg::resp_opc_t             r_opc   [soc_l2_pkg::NR_MASTERS];

    //////////////////////////////////////////////////////////////
    // Master ports into per-master vectors
    //////////////////////////////////////////////////////////////

    assign req[soc_l2_pkg::MASTER_FC_DATA]   = fc_data_req_i;
    assign add[soc_l2_pkg::MASTER_FC_DATA]   = fc_data_add_i;
    assign wen[soc_l2_pkg::MASTER_FC_DATA]   = fc_data_wen_i;
    assign wdata[soc_l2_pkg::MASTER_FC_DATA] = fc_data_wdata_i;
    assign be[soc_l2_pkg::MASTER_FC_DATA]    = fc_data_be_i;

    assign req[soc_l2_pkg::MASTER_UDMA]      = udma_req_i;
    assign add[soc_l2_pkg::MASTER_UDMA]      = udma_add_i;
    assign wen[soc_l2_pkg::MASTER_UDMA]      = udma_wen_i;
    assign wdata[soc_l2_pkg::MASTER_UDMA]    = udma_wdata_i;
    assign be[soc_l2_pkg::MASTER_UDMA]       = udma_be_i;

    // Grants and responses back out
    assign fc_data_gnt_o     = gnt[soc_l2_pkg::MASTER_FC_DATA];
    assign fc_data_r_valid_o = r_valid[soc_l2_pkg::MASTER_FC_DATA];
    assign fc_data_r_rdata_o = r_rdata[soc_l2_pkg::MASTER_FC_DATA];
    assign fc_data_r_opc_o   = r_opc[soc_l2_pkg::MASTER_FC_DATA];

    assign udma_gnt_o        = gnt[soc_l2_pkg::MASTER_UDMA];
    assign udma_r_valid_o    = r_valid[soc_l2_pkg::MASTER_UDMA];
    assign udma_r_rdata_o    = r_rdata[soc_l2_pkg::MASTER_UDMA];
    assign udma_r_opc_o      = r_opc[soc_l2_pkg::MASTER_UDMA];

    //////////////////////////////////////////////////////////////
    // Router, banks and response mux
    //////////////////////////////////////////////////////////////

    tcdm_bank_if bank_if [soc_l2_pkg::NR_BANKS] ();

    l2_req_router u_l2_req_router (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .req_i       (req),
        .add_i       (add),
        .wen_i       (wen),
        .wdata_i     (wdata),
        .be_i        (be),
        .gnt_o       (gnt),
        .err_valid_o (err_valid),
        .bank_if     (bank_if)
    );

    // Identical banks, bank b holds the words with address bits 3..2 == b
    for (genvar b = 0; b < soc_l2_pkg::NR_BANKS; b++) begin : gen_bank
        l2_bank u_l2_bank (
            .clk_i    (clk_i),
            .arst_n_i (arst_n_i),
            .bus      (bank_if[b])
        );
    end

    l2_resp_mux u_l2_resp_mux (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .bank_if     (bank_if),
        .err_valid_i (err_valid),
        .r_valid_o   (r_valid),
        .r_rdata_o   (r_rdata),
        .r_opc_o     (r_opc)
    );

endmodule

// File: verification/tb_soc_l2_interconnect.sv
// Directed testbench for the L2 interconnect
// Drives both TCDM masters, predicts every response from a reference
// memory model and prints one line per test plus a closing count
`timescale 1ns/100ps

module tb_soc_l2_interconnect;

    logic                  clk = 1'b0;
    logic                  arst_n;
    logic                  req     [soc_l2_pkg::NR_MASTERS];
    soc_l2_pkg::addr_t     add     [soc_l2_pkg::NR_MASTERS];
    logic                  wen     [soc_l2_pkg::NR_MASTERS];
    soc_l2_pkg::data_t     wdata   [soc_l2_pkg::NR_MASTERS];
    soc_l2_pkg::be_t       be      [soc_l2_pkg::NR_MASTERS];
    logic                  gnt     [soc_l2_pkg::NR_MASTERS];
    logic                  r_valid [soc_l2_pkg::NR_MASTERS];
    soc_l2_pkg::data_t     r_rdata [soc_l2_pkg::NR_MASTERS];
    soc_l2_pkg::resp_opc_t r_opc   [soc_l2_pkg::NR_MASTERS];

    // Reference memory over the whole region, known flags per byte
    soc_l2_pkg::data_t ref_mem   [soc_l2_pkg::NR_BANKS * soc_l2_pkg::BANK_WORDS];
    soc_l2_pkg::be_t   ref_known [soc_l2_pkg::NR_BANKS * soc_l2_pkg::BANK_WORDS];

    // Next operation per master, and the cycle in which it was granted
    logic              op_en     [soc_l2_pkg::NR_MASTERS];
    soc_l2_pkg::addr_t op_addr   [soc_l2_pkg::NR_MASTERS];
    logic              op_wen    [soc_l2_pkg::NR_MASTERS];
    soc_l2_pkg::data_t op_wdata  [soc_l2_pkg::NR_MASTERS];
    soc_l2_pkg::be_t   op_be     [soc_l2_pkg::NR_MASTERS];
    int                gnt_cycle [soc_l2_pkg::NR_MASTERS];

    integer seed;
    int     n_pass;
    int     n_fail;
    int     test_fail;

    soc_l2_interconnect u_soc_l2_interconnect (
        .clk_i             (clk),
        .arst_n_i          (arst_n),
        .fc_data_req_i     (req[0]),
        .fc_data_add_i     (add[0]),
        .fc_data_wen_i     (wen[0]),
        .fc_data_wdata_i   (wdata[0]),
        .fc_data_be_i      (be[0]),
        .fc_data_gnt_o     (gnt[0]),
        .fc_data_r_valid_o (r_valid[0]),
        .fc_data_r_rdata_o (r_rdata[0]),
        .fc_data_r_opc_o   (r_opc[0]),
        .udma_req_i        (req[1]),
        .udma_add_i        (add[1]),
        .udma_wen_i        (wen[1]),
        .udma_wdata_i      (wdata[1]),
        .udma_be_i         (be[1]),
        .udma_gnt_o        (gnt[1]),
        .udma_r_valid_o    (r_valid[1]),
        .udma_r_rdata_o    (r_rdata[1]),
        .udma_r_opc_o      (r_opc[1])
    );

    // 20 ns clock
    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic string port_name(input int m);
        return (m == 0) ? "fc_data" : "udma";
    endfunction

    function automatic soc_l2_pkg::data_t byte_mask(input soc_l2_pkg::be_t b);
        soc_l2_pkg::data_t mask;
        for (int i = 0; i < soc_l2_pkg::BE_W; i++) begin
            mask[i*8 +: 8] = {8{b[i]}};
        end
        return mask;
    endfunction

    // Applies one granted access, returns the expected response
    task automatic model_access(input int m, output soc_l2_pkg::resp_opc_t opc,
                                output soc_l2_pkg::data_t data, output soc_l2_pkg::data_t mask);
        soc_l2_pkg::addr_t a;
        soc_l2_pkg::data_t bm;
        int                idx;
        a    = op_addr[m];
        opc  = soc_l2_pkg::OPC_OK;
        data = '0;
        mask = '1;
        // Alias prefix only counts on the fc_data port
        if (m == 0 && a[31:20] == soc_l2_pkg::ALIAS_PREFIX) begin
            a[31:20] = soc_l2_pkg::L2_PREFIX;
        end
        if (a < soc_l2_pkg::L2_START_ADDR || a > soc_l2_pkg::L2_END_ADDR) begin
            opc = soc_l2_pkg::OPC_ERR;
        end else begin
            idx = int'((a - soc_l2_pkg::L2_START_ADDR) >> 2);
            if (!op_wen[m]) begin
                bm             = byte_mask(op_be[m]);
                ref_mem[idx]   = (ref_mem[idx] & ~bm) | (op_wdata[m] & bm);
                ref_known[idx] = ref_known[idx] | op_be[m];
            end else begin
                // Bytes never written are not compared
                data = ref_mem[idx];
                mask = byte_mask(ref_known[idx]);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Bus driving and checking
    ////////////////////////////////////////////////////////////

    task automatic tally(input logic ok);
        if (ok) begin
            n_pass++;
        end else begin
            n_fail++;
            test_fail++;
        end
    endtask

    task automatic check_resp(input int m, input soc_l2_pkg::resp_opc_t opc,
                              input soc_l2_pkg::data_t data, input soc_l2_pkg::data_t mask);
        logic ok;
        ok = 1'b1;
        if (r_valid[m] !== 1'b1) begin
            $display("[FAIL] %s_r_valid_o exp 0x1 got 0x%0h", port_name(m), r_valid[m]);
            ok = 1'b0;
        end
        if (r_opc[m] !== opc) begin
            $display("[FAIL] %s_r_opc_o exp 0x%0h got 0x%0h", port_name(m), opc, r_opc[m]);
            ok = 1'b0;
        end
        if (((r_rdata[m] ^ data) & mask) !== '0) begin
            $display("[FAIL] %s_r_rdata_o exp 0x%08h got 0x%08h", port_name(m),
                     data & mask, r_rdata[m] & mask);
            ok = 1'b0;
        end
        tally(ok);
    endtask

    task automatic clear_ops();
        for (int m = 0; m < soc_l2_pkg::NR_MASTERS; m++) begin
            op_en[m] = 1'b0;
        end
    endtask

    task automatic set_op(input int m, input soc_l2_pkg::addr_t a, input logic w,
                          input soc_l2_pkg::data_t d, input soc_l2_pkg::be_t b);
        op_en[m]    = 1'b1;
        op_addr[m]  = a;
        op_wen[m]   = w;
        op_wdata[m] = d;
        op_be[m]    = b;
    endtask

    // Issues the enabled ops together, holds req until gnt, checks each
    // response in the cycle after its grant. Inputs change on posedge,
    // outputs are sampled on negedge
    task automatic run_ops();
        logic [soc_l2_pkg::NR_MASTERS-1:0] pending;
        logic [soc_l2_pkg::NR_MASTERS-1:0] due;
        soc_l2_pkg::resp_opc_t             exp_opc  [soc_l2_pkg::NR_MASTERS];
        soc_l2_pkg::data_t                 exp_data [soc_l2_pkg::NR_MASTERS];
        soc_l2_pkg::data_t                 exp_mask [soc_l2_pkg::NR_MASTERS];
        int                                cyc;
        due = '0;
        cyc = 0;
        @(posedge clk);
        for (int m = 0; m < soc_l2_pkg::NR_MASTERS; m++) begin
            pending[m]   = op_en[m];
            gnt_cycle[m] = -1;
            if (op_en[m]) begin
                req[m]   <= 1'b1;
                add[m]   <= op_addr[m];
                wen[m]   <= op_wen[m];
                wdata[m] <= op_wdata[m];
                be[m]    <= op_be[m];
            end
        end
        while ((pending | due) != '0) begin
            @(negedge clk);
            for (int m = 0; m < soc_l2_pkg::NR_MASTERS; m++) begin
                if (due[m]) begin
                    check_resp(m, exp_opc[m], exp_data[m], exp_mask[m]);
                    due[m] = 1'b0;
                end else if (r_valid[m] !== 1'b0) begin
                    $display("[FAIL] %s_r_valid_o exp 0x0 got 0x%0h", port_name(m), r_valid[m]);
                    tally(1'b0);
                end
                if (pending[m] && gnt[m]) begin
                    model_access(m, exp_opc[m], exp_data[m], exp_mask[m]);
                    pending[m]   = 1'b0;
                    due[m]       = 1'b1;
                    gnt_cycle[m] = cyc;
                end else if (pending[m] && cyc >= 16) begin
                    $display("%s got no grant within 16 cycles, request dropped", port_name(m));
                    tally(1'b0);
                    pending[m] = 1'b0;
                end
            end
            @(posedge clk);
            for (int m = 0; m < soc_l2_pkg::NR_MASTERS; m++) begin
                if (!pending[m]) begin
                    req[m] <= 1'b0;
                end
            end
            cyc++;
        end
    endtask

    task automatic single_op(input int m, input soc_l2_pkg::addr_t a, input logic w,
                             input soc_l2_pkg::data_t d, input soc_l2_pkg::be_t b);
        clear_ops();
        set_op(m, a, w, d, b);
        run_ops();
    endtask

    task automatic report(input string name);
        if (test_fail == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_fail);
        end
        test_fail = 0;
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    // Stride of 17 words, bank = i % 4
    task automatic test_all_banks();
        soc_l2_pkg::addr_t a;
        for (int i = 0; i < 16; i++) begin
            a = soc_l2_pkg::L2_START_ADDR + 32'(i * 68);
            single_op(0, a, 1'b0, $random(seed), 4'hf);
        end
        for (int i = 0; i < 16; i++) begin
            a = soc_l2_pkg::L2_START_ADDR + 32'(i * 68);
            single_op(0, a, 1'b1, '0, 4'hf);
        end
        report("all_banks");
    endtask

    task automatic test_byte_enables();
        soc_l2_pkg::addr_t a;
        soc_l2_pkg::be_t   pat [4];
        pat = '{4'b0001, 4'b0110, 4'b1000, 4'b1010};
        for (int i = 0; i < 4; i++) begin
            a = soc_l2_pkg::L2_START_ADDR + 32'h200 + 32'(i * 4);
            single_op(0, a, 1'b0, $random(seed), 4'hf);
            single_op(1, a, 1'b0, $random(seed), pat[i]);
            single_op(0, a, 1'b1, '0, 4'hf);
        end
        report("byte_enables");
    endtask

    // Alias reaches L2 from fc_data only, udma gets an error
    task automatic test_alias();
        single_op(0, 32'h0000_0a48, 1'b0, $random(seed), 4'hf);
        single_op(0, 32'h1c00_0a48, 1'b1, '0, 4'hf);
        single_op(1, 32'h1c00_0a48, 1'b1, '0, 4'hf);
        single_op(1, 32'h0000_0a48, 1'b0, $random(seed), 4'hf);
        single_op(0, 32'h1c00_0a48, 1'b1, '0, 4'hf);
        report("alias");
    endtask

    task automatic check_immediate(input int m);
        if (gnt_cycle[m] != 0) begin
            $display("%s out-of-range request not granted in its first cycle", port_name(m));
            tally(1'b0);
        end else begin
            tally(1'b1);
        end
    endtask

    // Word 0 would be hit if the region end were decoded wrongly
    task automatic test_out_of_range();
        single_op(0, soc_l2_pkg::L2_END_ADDR + 32'd1, 1'b0, $random(seed), 4'hf);
        check_immediate(0);
        single_op(1, soc_l2_pkg::L2_START_ADDR - 32'd4, 1'b0, $random(seed), 4'hf);
        check_immediate(1);
        single_op(1, 32'h2000_0000, 1'b1, '0, 4'hf);
        check_immediate(1);
        single_op(0, soc_l2_pkg::L2_START_ADDR, 1'b1, '0, 4'hf);
        report("out_of_range");
    endtask

    // Same bank alternates winners, different banks go in parallel
    task automatic test_conflict();
        int win;
        int lose;
        for (int k = 0; k < 3; k++) begin
            win  = k % 2;
            lose = 1 - win;
            clear_ops();
            set_op(0, soc_l2_pkg::L2_START_ADDR + 32'h100, (k == 1), $random(seed), 4'hf);
            set_op(1, soc_l2_pkg::L2_START_ADDR + 32'h110, (k == 1), $random(seed), 4'hf);
            run_ops();
            if (gnt_cycle[win] != 0 || gnt_cycle[lose] <= gnt_cycle[win]) begin
                $display("conflict %0d: %s was not granted first", k, port_name(win));
                tally(1'b0);
            end else begin
                tally(1'b1);
            end
        end
        clear_ops();
        set_op(0, soc_l2_pkg::L2_START_ADDR + 32'h104, 1'b0, $random(seed), 4'hf);
        set_op(1, soc_l2_pkg::L2_START_ADDR + 32'h118, 1'b0, $random(seed), 4'hf);
        run_ops();
        if (gnt_cycle[0] != 0 || gnt_cycle[1] != 0) begin
            $display("requests to different banks were not granted in the same cycle");
            tally(1'b0);
        end else begin
            tally(1'b1);
        end
        report("conflict");
    endtask

    task automatic test_random();
        soc_l2_pkg::addr_t a;
        logic [31:0]       rnd;
        for (int i = 0; i < 100; i++) begin
            clear_ops();
            for (int m = 0; m < soc_l2_pkg::NR_MASTERS; m++) begin
                rnd = $random(seed);
                a   = soc_l2_pkg::L2_START_ADDR + {20'h0, rnd[9:0], 2'b00};
                // fc_data sometimes goes through the alias
                if (m == 0 && rnd[10]) begin
                    a[31:20] = soc_l2_pkg::ALIAS_PREFIX;
                end
                set_op(m, a, rnd[11], $random(seed), rnd[15:12]);
            end
            run_ops();
        end
        report("random");
    endtask

    ////////////////////////////////////////////////////////////
    // Watchdog and main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int total_ops;
        int limit_cycles;
        total_ops    = 32 + 12 + 5 + 4 + 8 + 200;
        limit_cycles = total_ops * 4 + 8 + 200;
        #(limit_cycles * 20);
        $display("Watchdog expired after %0d cycles, simulation stopped", limit_cycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        seed      = 32'hef8e86e7;
        n_pass    = 0;
        n_fail    = 0;
        test_fail = 0;
        arst_n    = 1'b0;
        for (int m = 0; m < soc_l2_pkg::NR_MASTERS; m++) begin
            req[m]   = 1'b0;
            add[m]   = '0;
            wen[m]   = 1'b1;
            wdata[m] = '0;
            be[m]    = '0;
            op_en[m] = 1'b0;
        end
        for (int i = 0; i < soc_l2_pkg::NR_BANKS * soc_l2_pkg::BANK_WORDS; i++) begin
            ref_mem[i]   = '0;
            ref_known[i] = '0;
        end
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);

        test_all_banks();
        test_byte_enables();
        test_alias();
        test_out_of_range();
        test_conflict();
        test_random();

        $display("checks passed: %0d, checks failed: %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
verilog/soc_l2_pkg.sv
verilog/tcdm_bank_if.sv
verilog/l2_req_router.sv
verilog/l2_bank.sv
verilog/l2_resp_mux.sv
verilog/soc_l2_interconnect.sv
verification/tb_soc_l2_interconnect.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the L2 interconnect testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_soc_l2_interconnect \
    -f vlog.f \
    --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out="$(./obj_dir/sim_tb)"
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Test passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
